/* Makefile */
VERILATOR ?= verilator
TOP       := agu_tb
FILELIST  := agu_top.f
FLAGS     := --binary --assert
BUILD_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* agu/agu_bank_map.sv */
// ##########################################################
// agu_bank_map
// decodes the operation size and works out which 4-byte
// banks of the line an access touches, where it starts and
// whether it runs past the last bank
// ##########################################################

module agu_bank_map #(
  parameter int bank_count = 32
) (
  input  logic [12:0]                           op,
  input  logic [$clog2(bank_count)+1:0]         addr_low,
  output agu_pkg::size_class_t                  size,
  output logic [bank_count-1:0]                 banks,
  output logic [$clog2(bank_count)-1:0]         bank0,
  output logic                                  split
);

  localparam int bw = $clog2(bank_count);

  logic [1:0]    lo;
  logic [2:0]    n_banks;
  logic [bw:0]   bank_end;
  logic [bw-1:0] off;

  assign lo = addr_low[1:0];
  assign bank0 = addr_low[bw+1:2];

  // size field is op[5:1]
  always_comb begin
    case (op[5:1])
      5'd16: size = agu_pkg::sz_byte;
      5'd17: size = agu_pkg::sz_half;
      5'd18: size = agu_pkg::sz_word;
      5'd19: size = agu_pkg::sz_dword;
      5'd3: size = agu_pkg::sz_ten_byte;
      5'd0, 5'd1, 5'd2: size = agu_pkg::sz_quad;
      5'd4, 5'd5, 5'd6: size = agu_pkg::sz_word;
      5'd8, 5'd9, 5'd10: size = agu_pkg::sz_dword;
      5'd15: size = agu_pkg::sz_fill_spill;
      default: size = agu_pkg::sz_dword;
    endcase
  end

  // misaligned starts spill one more bank
  always_comb begin
    case (size)
      agu_pkg::sz_byte: n_banks = 3'd1;
      agu_pkg::sz_half: n_banks = 3'd1 + {2'b00, lo == 2'd3};
      agu_pkg::sz_word: n_banks = 3'd1 + {2'b00, lo != 2'd0};
      agu_pkg::sz_dword: n_banks = 3'd2 + {2'b00, lo != 2'd0};
      agu_pkg::sz_ten_byte: n_banks = 3'd3 + {2'b00, lo == 2'd3};
      agu_pkg::sz_quad: n_banks = 3'd4 + {2'b00, lo != 2'd0};
      agu_pkg::sz_fill_spill: n_banks = 3'd5;
      default: n_banks = 3'd2;
    endcase
  end

  // banks run from bank0 upward and wrap around the line
  always_comb begin
    banks = '0;
    off = '0;
    for (int i = 0; i < bank_count; i++) begin
      off = bw'(i) - bank0;
      banks[i] = off < bw'(n_banks);
    end
  end

  assign bank_end = {1'b0, bank0} + (bw + 1)'(n_banks);
  // past the top bank means the access continues in the next line
  assign split = bank_end > (bw + 1)'(bank_count);

endmodule

/* agu/agu_fault_check.sv */
// ##########################################################
// agu_fault_check
// page fault checks on the current and next TLB entries,
// registered into the fault report one cycle later
// ##########################################################

module agu_fault_check (
  input  logic                clk,
  input  logic                rst,
  input  logic                stall,
  input  logic                en,
  input  logic                tlb_hit,
  input  logic                user,
  input  logic                top_ok,
  input  logic                cross_page,
  input  logic                split,
  input  agu_pkg::tlb_entry_t tlb_cur,
  input  agu_pkg::tlb_entry_t tlb_next,
  output agu_pkg::fault_t     fault
);

  logic next_used;
  logic na_fault;
  logic sys_fault;
  logic valid;

  // the next page entry only counts when the access really reaches it
  assign next_used = split & cross_page;

  assign na_fault = ~tlb_cur.na | (next_used & ~tlb_next.na);

  // user code may not touch system pages nor the top address region
  assign sys_fault = user & (tlb_cur.sys | (next_used & tlb_next.sys) | ~top_ok);

  assign valid = en & tlb_hit;

  always_ff @(posedge clk) begin
    if (rst) begin
      fault <= '0;
    end else if (!stall) begin
      fault.page_fault <= valid & (na_fault | sys_fault);
      fault.fault_code <= {6'b000000, valid & sys_fault, valid & na_fault};
    end
  end

endmodule

/* agu/agu_proc_regs.sv */
// ##########################################################
// agu_proc_regs
// per-thread page and vm page process numbers, written
// through the CSR port, and the selection of the number
// used for the TLB lookup
// ##########################################################

module agu_proc_regs #(
  parameter int proc_w = 24
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              csr_en,
  input  logic [15:0]       csr_no,
  input  logic [63:0]       csr_data,
  input  logic              thread,
  input  logic              vm,
  output logic [proc_w-1:0] proc,
  output logic [proc_w-1:0] sproc
);

  logic [1:0][proc_w-1:0] page_r;
  logic [1:0][proc_w-1:0] vmpage_r;

  // csr_no[15] picks the thread, number comes from the top bits
  always_ff @(posedge clk) begin
    if (rst) begin
      page_r <= '0;
      vmpage_r <= '0;
    end else if (csr_en) begin
      case (csr_no[14:0])
        agu_pkg::csr_page: page_r[csr_no[15]] <= csr_data[63 -: proc_w];
        agu_pkg::csr_vmpage: vmpage_r[csr_no[15]] <= csr_data[63 -: proc_w];
        default: ;
      endcase
    end
  end

  // in vm mode the guest number drives lookup, host number goes out flipped
  always_comb begin
    if (vm) begin
      proc = vmpage_r[thread];
      sproc = page_r[thread] ^ proc_w'(1);
    end else begin
      proc = page_r[thread];
      sproc = '0;
    end
  end

endmodule

/* agu/agu_stage.sv */
// ##########################################################
// agu_stage
// stall-able request register and assembly of the memory
// operation: even and odd line addresses, main physical
// address, banks and queue tags, plus the TLB lookup address
// ##########################################################

module agu_stage #(
  parameter int page_bits = 13,
  parameter int line_bit = 7
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                stall,
  input  logic                                except,
  input  logic                                read_en,
  input  agu_pkg::agu_req_t                   req,
  input  agu_pkg::size_class_t                size,
  input  logic [agu_pkg::bank_count-1:0]      banks,
  input  logic [4:0]                          bank0,
  input  logic                                split,
  input  logic [agu_pkg::tlb_addr_w - agu_pkg::vaddr_w + page_bits - 1:0] proc_low,
  input  logic                                tlb_hit,
  input  agu_pkg::tlb_entry_t                 tlb_cur,
  input  agu_pkg::tlb_entry_t                 tlb_next,
  output logic [agu_pkg::tlb_addr_w-1:0]      tlb_addr,
  output logic                                en,
  output logic                                tlb_miss,
  output logic                                cross_page,
  output logic                                top_ok,
  output logic                                user,
  output agu_pkg::mop_t                       mop
);

  agu_pkg::agu_req_t                  req_q;
  agu_pkg::size_class_t               size_q;
  logic [agu_pkg::bank_count-1:0]     banks_q;
  logic [4:0]                         bank0_q;
  logic                               split_q;
  logic                               except_q;
  logic [page_bits+1:0]               addr_next;
  logic                               odd;
  logic [agu_pkg::phys_w-1:0]         even_page;
  logic [agu_pkg::phys_w-1:0]         odd_page;

  // lookup address is formed straight from the incoming request
  assign tlb_addr = {proc_low, req.vaddr[agu_pkg::vaddr_w-1:page_bits]};

  // except_q remembers last cycle's except even across a stall
  always_ff @(posedge clk) begin
    if (rst) begin
      en <= 1'b0;
      except_q <= 1'b0;
    end else begin
      except_q <= except;
      if (!stall)
        en <= read_en & ~except & ~except_q;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      req_q <= req;
      size_q <= size;
      banks_q <= banks;
      bank0_q <= bank0;
      split_q <= split;
    end
  end

  // address of the following line
  assign addr_next = {1'b0, req_q.vaddr[page_bits:0]} + (page_bits + 2)'(1 << line_bit);
  assign cross_page = addr_next[page_bits+1];
  assign odd = req_q.vaddr[line_bit];

  // odd start means the even line is the following one, and vice versa
  assign even_page = (odd & cross_page) ? tlb_next.phys : tlb_cur.phys;
  assign odd_page = (~odd & cross_page) ? tlb_next.phys : tlb_cur.phys;

  assign top_ok = ~&req_q.vaddr[42:41];
  assign user = ~req_q.attr.km;

  assign tlb_miss = en & ~tlb_hit & ~except;

  always_comb begin
    mop.en = en & tlb_hit & ~except;
    mop.store = req_q.op[0];
    // decoded size class
    mop.sz = {2'b00, size_q};
    mop.invtlb = req_q.op[7];
    if (odd) begin
      mop.addr_even = {even_page, addr_next[page_bits-1:line_bit+1]};
      mop.addr_odd = {odd_page, req_q.vaddr[page_bits-1:line_bit+1]};
    end else begin
      mop.addr_even = {even_page, req_q.vaddr[page_bits-1:line_bit+1]};
      mop.addr_odd = {odd_page, addr_next[page_bits-1:line_bit+1]};
    end
    mop.addr_main = {tlb_cur.phys, req_q.vaddr[page_bits-1:0]};
    mop.banks = banks_q & {agu_pkg::bank_count{en}};
    mop.bank0 = bank0_q;
    mop.odd = odd;
    mop.split = split_q;
    mop.mem_type = tlb_cur.mem_type;
    mop.reg_no = req_q.reg_no;
    mop.lsq_no = req_q.lsq_no;
    mop.ii_no = req_q.ii_no;
    mop.wq_no = req_q.wq_no;
    mop.thread = req_q.thread;
  end

endmodule

/* agu/agu_top.sv */
// ##########################################################
// agu_top
// load/store address generation unit for one memory port,
// joining bank map, process registers, request stage,
// fault check and the external TLB
// ##########################################################

module agu_top #(
  parameter int bank_count = agu_pkg::bank_count,
  parameter int proc_w = agu_pkg::proc_w,
  parameter int page_bits = agu_pkg::page_bits,
  parameter int line_bit = agu_pkg::line_bit
) (
  input  logic                           clk,
  input  logic                           rst,
  input  agu_pkg::agu_req_t              req,
  input  logic                           read_en,
  input  logic                           stall,
  input  logic                           except,
  input  logic                           csr_en,
  input  logic [15:0]                    csr_no,
  input  logic [63:0]                    csr_data,
  input  logic                           tlb_hit,
  input  agu_pkg::tlb_entry_t            tlb_cur,
  input  agu_pkg::tlb_entry_t            tlb_next,
  output logic [agu_pkg::tlb_addr_w-1:0] tlb_addr,
  output logic                           tlb_en,
  output logic [proc_w-1:0]              sproc,
  output logic                           tlb_miss,
  output agu_pkg::mop_t                  mop,
  output agu_pkg::fault_t                fault
);

  agu_pkg::size_class_t  size;
  logic [bank_count-1:0] banks;
  logic [4:0]            bank0;
  logic                  split;
  logic [proc_w-1:0]     proc;
  logic                  cross_page;
  logic                  top_ok;
  logic                  user;

  agu_bank_map #(
    .bank_count(bank_count)
  ) u_bank_map (
    .op(req.op),
    .addr_low(req.vaddr[6:0]),
    .size(size),
    .banks(banks),
    .bank0(bank0),
    .split(split)
  );

  agu_proc_regs #(
    .proc_w(proc_w)
  ) u_proc_regs (
    .clk(clk),
    .rst(rst),
    .csr_en(csr_en),
    .csr_no(csr_no),
    .csr_data(csr_data),
    .thread(req.thread),
    .vm(req.attr.vm),
    .proc(proc),
    .sproc(sproc)
  );

  agu_stage #(
    .page_bits(page_bits),
    .line_bit(line_bit)
  ) u_stage (
    .clk(clk),
    .rst(rst),
    .stall(stall),
    .except(except),
    .read_en(read_en),
    .req(req),
    .size(size),
    .banks(banks),
    .bank0(bank0),
    .split(split),
    .proc_low(proc[20:0]),
    .tlb_hit(tlb_hit),
    .tlb_cur(tlb_cur),
    .tlb_next(tlb_next),
    .tlb_addr(tlb_addr),
    .en(tlb_en),
    .tlb_miss(tlb_miss),
    .cross_page(cross_page),
    .top_ok(top_ok),
    .user(user),
    .mop(mop)
  );

  agu_fault_check u_fault_check (
    .clk(clk),
    .rst(rst),
    .stall(stall),
    .en(tlb_en),
    .tlb_hit(tlb_hit),
    .user(user),
    .top_ok(top_ok),
    .cross_page(cross_page),
    .split(mop.split),
    .tlb_cur(tlb_cur),
    .tlb_next(tlb_next),
    .fault(fault)
  );

endmodule

/* agu_top.f */
common/agu_pkg.sv
agu/agu_bank_map.sv
agu/agu_proc_regs.sv
agu/agu_fault_check.sv
agu/agu_stage.sv
agu/agu_top.sv
verification/agu_chk.sv
verification/agu_tb.sv

/* common/agu_pkg.sv */
// ##########################################################
// agu_pkg
// shared widths, size classes, CSR numbers and the structs
// that carry requests, TLB entries, results and fault reports
// for the load/store address generation unit
// ##########################################################

package agu_pkg;

  localparam int vaddr_w = 44;
  localparam int paddr_w = 44;
  // 8 KiB pages
  localparam int page_bits = 13;
  // 32 banks of 4 bytes, 128-byte line
  localparam int bank_count = 32;
  localparam int line_bit = 7;
  localparam int proc_w = 24;
  localparam int tlb_addr_w = 52;
  localparam int phys_w = paddr_w - page_bits;

  // CSR register numbers, thread select lives in csr_no[15]
  localparam logic [14:0] csr_page = 15'h0004;
  localparam logic [14:0] csr_vmpage = 15'h0005;

  typedef enum logic [2:0] {
    sz_byte,
    sz_half,
    sz_word,
    sz_dword,
    sz_ten_byte,
    sz_quad,
    sz_fill_spill
  } size_class_t;

  typedef struct packed {
    logic [phys_w-1:0] phys;
    logic              na;
    logic              sys;
    logic [1:0]        mem_type;
  } tlb_entry_t;

  typedef struct packed {
    logic spare;
    logic sec;
    logic km;
    logic vm;
  } attr_t;

  typedef struct packed {
    logic [12:0]        op;
    logic [vaddr_w-1:0] vaddr;
    logic [8:0]         reg_no;
    logic [8:0]         lsq_no;
    logic [9:0]         ii_no;
    logic [5:0]         wq_no;
    logic               thread;
    attr_t              attr;
  } agu_req_t;

  typedef struct packed {
    logic                            en;
    logic                            store;
    logic [4:0]                      sz;
    logic                            invtlb;
    logic [paddr_w-1:line_bit+1]     addr_even;
    logic [paddr_w-1:line_bit+1]     addr_odd;
    logic [paddr_w-1:0]              addr_main;
    logic [bank_count-1:0]           banks;
    logic [4:0]                      bank0;
    logic                            odd;
    logic                            split;
    logic [1:0]                      mem_type;
    logic [8:0]                      reg_no;
    logic [8:0]                      lsq_no;
    logic [9:0]                      ii_no;
    logic [5:0]                      wq_no;
    logic                            thread;
  } mop_t;

  typedef struct packed {
    logic       page_fault;
    logic [7:0] fault_code;
  } fault_t;

endpackage

/* verification/agu_chk.sv */
// ##########################################################
// agu_chk
// concurrent checks on the AGU outputs, bound into agu_top
// ##########################################################

module agu_chk (
  input logic            clk,
  input logic            rst,
  input logic            stall,
  input logic            tlb_en,
  input logic            tlb_miss,
  input agu_pkg::mop_t   mop,
  input agu_pkg::fault_t fault
);

  timeunit 1ns;
  timeprecision 100ps;

  // a hit and a miss cannot both be reported
  miss_or_hit: assert property (@(posedge clk) disable iff (rst) !(tlb_miss && mop.en))
    else $error("tlb_miss and mop.en high together");

  // a new page fault needs a live stage and an unstalled edge
  fault_source: assert property (@(posedge clk) disable iff (rst)
    $rose(fault.page_fault) |-> $past(tlb_en) && !$past(stall))
    else $error("page_fault set without a preceding request");

  fault_hold: assert property (@(posedge clk) disable iff (rst)
    !$past(rst) && $past(stall) |-> $stable(fault))
    else $error("fault changed during stall");

  reset_quiet: assert property (@(posedge clk) disable iff (rst)
    $past(rst) |-> !tlb_en && !tlb_miss && !mop.en && !fault.page_fault)
    else $error("outputs active right after reset");

endmodule

bind agu_top agu_chk u_chk (.*);

/* verification/agu_golden.txt */
// ctl csr_no csr_data op vaddr tlb_cur tlb_next | tlb_addr sproc flags banks even odd main fault
// ctl: 0 read_en 1 exc0 2 exc1 3 thread 4 vm 5 km 6 hit 15:8 stall; csr_no bit 16 is csr_en
// flags: 0 en 1 tlb_miss 2 split 12:8 bank0 18:16 size; all-ones word ends the list
61 0 0 20 A000 1009 1019 5 0 1 1 2000 2000 200000 0
61 0 0 22 A047 1009 1019 5 0 11101 60000 2000 2000 200047 0
61 0 0 24 A07D 1009 1019 5 0 21F05 80000001 2000 2000 20007D 0
61 0 0 26 A07E 1009 1019 5 0 31F05 80000003 2000 2000 20007E 0
61 0 0 06 A047 1009 1019 5 0 41101 1E0000 2000 2000 200047 0
61 0 0 00 A000 1009 1019 5 0 50001 F 2000 2000 200000 0
61 0 0 1E A07C 1009 1019 5 0 61F05 8000000F 2000 2000 20007C 0
61 0 0 00 A07D 1009 1019 5 0 51F05 8000000F 2000 2000 20007D 0
61 0 0 24 BF84 1009 1019 5 0 20101 2 2020 201F 201F84 0
61 0 0 24 A380 1009 1019 5 0 20001 1 2004 2003 200380 0
41 0 0 26 BFFE 1009 1015 5 0 31F05 80000003 2020 201F 201FFE 103
61 0 0 20 A000 1005 1019 5 0 1 1 2000 2000 200000 101
41 0 0 20 A000 100D 1019 5 0 1 1 2000 2000 200000 102
21 0 0 20 A000 1009 1019 5 0 2 1 2000 2000 200000 0
63 0 0 20 A000 1009 1019 5 0 0 0 2000 2000 200000 0
65 0 0 20 A000 1009 1019 5 0 0 1 2000 2000 200000 0
361 0 0 20 A000 1009 1019 5 0 1 1 2000 2000 200000 0
261 0 0 20 A000 1005 1019 5 0 1 1 2000 2000 200000 101
61 10004 ABCDEF0000000000 20 A000 1009 1019 5E6F780000005 0 1 1 2000 2000 200000 0
79 18005 1234560000000000 20 A000 1009 1019 91A2B00000005 1 1 1 2000 2000 200000 0
79 18004 0000100000000000 20 A000 1009 1019 91A2B00000005 11 1 1 2000 2000 200000 0
69 0 0 20 A000 1009 1019 800000005 0 1 1 2000 2000 200000 0
FFFFFFFFFFFFFFFF

/* verification/agu_tb.sv */
// ##########################################################
// agu_tb
// testbench for the AGU that replays requests, CSR writes
// and TLB answers from the golden file and compares
// tlb_addr, sproc, tlb_en, mop, tlb_miss and the fault report
// ##########################################################

module agu_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int words = 15;
  localparam int max_vec = 64;
  localparam int period = 8;

  logic                  clk;
  logic                  rst;
  agu_pkg::agu_req_t     req;
  logic                  read_en;
  logic                  stall;
  logic                  except;
  logic                  csr_en;
  logic [15:0]           csr_no;
  logic [63:0]           csr_data;
  logic                  tlb_hit;
  agu_pkg::tlb_entry_t   tlb_cur;
  agu_pkg::tlb_entry_t   tlb_next;
  logic [51:0]           tlb_addr;
  logic                  tlb_en;
  logic [23:0]           sproc;
  logic                  tlb_miss;
  agu_pkg::mop_t         mop;
  agu_pkg::fault_t       fault;

  logic [63:0] golden [0:words*max_vec-1];
  int          n_vec;
  bit          loaded;

  agu_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  task automatic report_fail();
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic step_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic idle_inputs();
    req = '0;
    read_en = 1'b0;
    except = 1'b0;
    stall = 1'b0;
    csr_en = 1'b0;
    csr_no = '0;
    csr_data = '0;
    tlb_hit = 1'b0;
    tlb_cur = '0;
    tlb_next = '0;
  endtask

  task automatic check_mop(input int v, input agu_pkg::mop_t exp);
    if (mop !== exp) begin
      $display("ERROR vector %0d mop exp %h got %h", v, exp, mop);
      report_fail();
    end
  endtask

  task automatic check_fault(input int v, input agu_pkg::fault_t exp);
    if (fault !== exp) begin
      $display("ERROR vector %0d fault exp %h got %h", v, exp, fault);
      report_fail();
    end
  endtask

  task automatic check_tlb_addr(input int v, input logic [51:0] exp);
    if (tlb_addr !== exp) begin
      $display("ERROR vector %0d tlb_addr exp %h got %h", v, exp, tlb_addr);
      report_fail();
    end
  endtask

  task automatic check_sproc(input int v, input logic [23:0] exp);
    if (sproc !== exp) begin
      $display("ERROR vector %0d sproc exp %h got %h", v, exp, sproc);
      report_fail();
    end
  endtask

  task automatic check_miss(input int v, input logic exp);
    if (tlb_miss !== exp) begin
      $display("ERROR vector %0d tlb_miss exp %h got %h", v, exp, tlb_miss);
      report_fail();
    end
  endtask

  task automatic check_tlb_en(input int v, input logic exp);
    if (tlb_en !== exp) begin
      $display("ERROR vector %0d tlb_en exp %h got %h", v, exp, tlb_en);
      report_fail();
    end
  endtask

  // queue tags vary per vector so a stale register shows up
  function automatic agu_pkg::agu_req_t make_req(input int v, input int b);
    agu_pkg::agu_req_t r;
    r = '0;
    r.op = golden[b+3][12:0];
    r.vaddr = golden[b+4][43:0];
    r.reg_no = 9'(v * 3 + 1);
    r.lsq_no = 9'(v * 5 + 2);
    r.ii_no = 10'(v * 7 + 3);
    r.wq_no = 6'(v + 4);
    r.thread = golden[b][3];
    r.attr.vm = golden[b][4];
    r.attr.km = golden[b][5];
    return r;
  endfunction

  function automatic agu_pkg::mop_t expect_mop(input int b, input agu_pkg::agu_req_t r);
    agu_pkg::mop_t       m;
    agu_pkg::tlb_entry_t cur;
    logic [63:0]         flags;
    cur = golden[b+5][34:0];
    flags = golden[b+9];
    m = '0;
    m.en = flags[0];
    m.store = r.op[0];
    m.sz = {2'b00, flags[18:16]};
    m.invtlb = r.op[7];
    m.addr_even = golden[b+11][35:0];
    m.addr_odd = golden[b+12][35:0];
    m.addr_main = golden[b+13][43:0];
    m.banks = golden[b+10][31:0];
    m.bank0 = flags[12:8];
    m.odd = r.vaddr[7];
    m.split = flags[2];
    m.mem_type = cur.mem_type;
    m.reg_no = r.reg_no;
    m.lsq_no = r.lsq_no;
    m.ii_no = r.ii_no;
    m.wq_no = r.wq_no;
    m.thread = r.thread;
    return m;
  endfunction

  // csr cycle if any, cycle 0 request, cycle 1 TLB answer with stalls, cycle 2 fault
  task automatic run_vector(input int v);
    int                b;
    int                n_stall;
    logic [63:0]       ctl;
    logic              exp_en;
    agu_pkg::agu_req_t r;
    agu_pkg::mop_t     exp_m;
    b = v * words;
    ctl = golden[b];
    n_stall = int'(ctl[15:8]);
    // except is low in the cycle before every request
    exp_en = ctl[0] & ~ctl[1];
    if (golden[b+1][16]) begin
      csr_en = 1'b1;
      csr_no = golden[b+1][15:0];
      csr_data = golden[b+2];
      step_cycle();
      csr_en = 1'b0;
    end
    r = make_req(v, b);
    req = r;
    read_en = ctl[0];
    except = ctl[1];
    #2;
    check_tlb_addr(v, golden[b+7][51:0]);
    check_sproc(v, golden[b+8][23:0]);
    step_cycle();
    req = '0;
    read_en = 1'b0;
    except = ctl[2];
    tlb_hit = ctl[6];
    tlb_cur = golden[b+5][34:0];
    tlb_next = golden[b+6][34:0];
    exp_m = expect_mop(b, r);
    for (int i = 0; i <= n_stall; i++) begin
      stall = i < n_stall;
      #2;
      check_mop(v, exp_m);
      check_miss(v, golden[b+9][1]);
      check_tlb_en(v, exp_en);
      step_cycle();
    end
    idle_inputs();
    #2;
    check_fault(v, golden[b+14][8:0]);
    step_cycle();
  endtask

  initial begin
    bit done;
    idle_inputs();
    rst = 1'b1;
    n_vec = 0;
    loaded = 0;
    done = 0;
    $readmemh("verification/agu_golden.txt", golden);
    while (!done) begin
      if (n_vec == max_vec || $isunknown(golden[n_vec*words])) begin
        $display("golden file ended without its end marker");
        report_fail();
      end else if (golden[n_vec*words] == '1) begin
        done = 1;
      end else begin
        n_vec++;
      end
    end
    loaded = 1;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int v = 0; v < n_vec; v++)
      run_vector(v);
    $display("ALL TESTS PASSED");
    $finish;
  end

  initial begin
    wait (loaded);
    #((n_vec * 3 + 100) * period);
    $display("timeout: the run did not finish in time");
    report_fail();
  end

endmodule
